// File: source/aux_pkg.sv
package aux_pkg;

    // ========================================
    // Request and reply encodings
    // ========================================

    // Native request opcodes, added to AUX_HDR_CMD_BASE in the header
    typedef enum logic [1:0] {
        CMD_WRITE = 2'b00,
        CMD_READ  = 2'b01
    } aux_cmd_e;

    // Reply code taken from the upper nibble of the first reply byte
    typedef enum logic [1:0] {
        ACK_ACK   = 2'b00,
        ACK_NACK  = 2'b01,
        ACK_DEFER = 2'b10
    } aux_ack_e;

    typedef enum logic {
        OWNER_SPM = 1'b0,
        OWNER_LPM = 1'b1
    } aux_owner_e;

    // 38-bit native request, len is byte count minus one
    typedef struct packed {
        aux_cmd_e    cmd;
        logic [19:0] address;
        logic [7:0]  len;
        logic [7:0]  data;
    } aux_req_t;

    // ========================================
    // State machines
    // ========================================

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_REPLY,
        DONE
    } ctrl_state_e;

    // Encoder idle state is prefixed, IDLE already belongs to the control FSM
    typedef enum logic [1:0] {
        ENC_IDLE,
        HEADER,
        PAYLOAD
    } enc_state_e;

    // ========================================
    // Timing and retry limits
    // ========================================

    localparam int AUX_MAX_RETRY     = 3;
    localparam int AUX_REPLY_TIMEOUT = 32;
    localparam int HPD_PLUG_CYCLES   = 20;
    localparam int HPD_IRQ_MIN       = 4;
    localparam int HPD_IRQ_MAX       = 10;
    localparam int AUX_HDR_CMD_BASE  = 8;

    // Header is command/address, address, address, length
    localparam int AUX_HDR_BYTES = 4;

    // Counter widths
    localparam int AUX_RETRY_W = $clog2(AUX_MAX_RETRY + 1);
    localparam int AUX_TIMER_W = $clog2(AUX_REPLY_TIMEOUT);
    localparam int HPD_CNT_W   = $clog2(HPD_PLUG_CYCLES + 1);

endpackage

// File: source/aux_ctrl_unit.sv
module aux_ctrl_unit import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spm_transaction_vld,
    input  aux_req_t   spm_req,
    input  logic       lpm_transaction_vld,
    input  aux_req_t   lpm_req,
    input  aux_ack_e   reply_ack,
    input  logic       reply_ack_vld,
    input  logic       rx_end,
    input  logic       timer_timeout,
    input  logic       tx_done,
    output logic       tx_start,
    output aux_req_t   tx_req,
    output logic       req_done,
    output aux_owner_e reply_owner,
    output logic       ctrl_native_failed
);

    ctrl_state_e            state;
    aux_ack_e               ack_q;
    aux_ack_e               ack_now;
    logic [AUX_RETRY_W-1:0] retry_cnt;
    logic                   retries_spent;

    // A one-byte reply ends on the same cycle its ack code is registered
    assign ack_now       = reply_ack_vld ? reply_ack : ack_q;
    assign retries_spent = (retry_cnt == AUX_RETRY_W'(AUX_MAX_RETRY));

    // Winning request, lpm has priority
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (lpm_transaction_vld) begin
                tx_req <= lpm_req;
            end else if (spm_transaction_vld) begin
                tx_req <= spm_req;
            end
        end
        if (reply_ack_vld) begin
            ack_q <= reply_ack;
        end
    end

    // ========================================
    // Transaction FSM
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state              <= IDLE;
            tx_start           <= 1'b0;
            req_done           <= 1'b0;
            ctrl_native_failed <= 1'b0;
            retry_cnt          <= '0;
            reply_owner        <= OWNER_SPM;
        end else begin
            tx_start           <= 1'b0;
            req_done           <= 1'b0;
            ctrl_native_failed <= 1'b0;
            case (state)
                IDLE: begin
                    if (lpm_transaction_vld || spm_transaction_vld) begin
                        reply_owner <= lpm_transaction_vld ? OWNER_LPM : OWNER_SPM;
                        retry_cnt   <= '0;
                        tx_start    <= 1'b1;
                        state       <= SEND;
                    end
                end
                SEND: begin
                    if (tx_done) begin
                        state <= WAIT_REPLY;
                    end
                end
                WAIT_REPLY: begin
                    if (rx_end && ack_now == ACK_ACK) begin
                        req_done <= 1'b1;
                        state    <= DONE;
                    end else if (rx_end || timer_timeout) begin
                        // NACK, DEFER or no reply at all
                        if (retries_spent) begin
                            req_done           <= 1'b1;
                            ctrl_native_failed <= 1'b1;
                            state              <= DONE;
                        end else begin
                            retry_cnt <= retry_cnt + 1'b1;
                            tx_start  <= 1'b1;
                            state     <= SEND;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/native_message_encoder.sv
module native_message_encoder import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  aux_req_t   tx_req,
    output logic [7:0] tx_byte,
    output logic       tx_byte_vld,
    output logic       tx_done
);

    enc_state_e state;
    logic [2:0] byte_idx;
    logic [3:0] cmd_nibble;
    logic       last_hdr;

    assign cmd_nibble = 4'(AUX_HDR_CMD_BASE) + {2'b00, tx_req.cmd};
    assign last_hdr   = (byte_idx == 3'(AUX_HDR_BYTES - 1));

    // Byte select, request stays stable for the whole frame
    always_comb begin
        case (byte_idx)
            3'd0:    tx_byte = {cmd_nibble, tx_req.address[19:16]};
            3'd1:    tx_byte = tx_req.address[15:8];
            3'd2:    tx_byte = tx_req.address[7:0];
            3'd3:    tx_byte = tx_req.len;
            default: tx_byte = tx_req.data;
        endcase
    end

    // ========================================
    // Frame sequencing
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ENC_IDLE;
            byte_idx    <= '0;
            tx_byte_vld <= 1'b0;
            tx_done     <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                ENC_IDLE: begin
                    if (tx_start) begin
                        byte_idx    <= '0;
                        tx_byte_vld <= 1'b1;
                        state       <= HEADER;
                    end
                end
                HEADER: begin
                    if (!last_hdr) begin
                        byte_idx <= byte_idx + 1'b1;
                    end else if (tx_req.cmd == CMD_WRITE) begin
                        // Single data byte follows the length
                        byte_idx <= byte_idx + 1'b1;
                        state    <= PAYLOAD;
                    end else begin
                        tx_byte_vld <= 1'b0;
                        tx_done     <= 1'b1;
                        state       <= ENC_IDLE;
                    end
                end
                PAYLOAD: begin
                    tx_byte_vld <= 1'b0;
                    tx_done     <= 1'b1;
                    state       <= ENC_IDLE;
                end
                default: begin
                    tx_byte_vld <= 1'b0;
                    state       <= ENC_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/aux_phy_interface.sv
module aux_phy_interface import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_byte_vld,
    input  logic       phy_start_stop,
    inout  wire  [7:0] aux_in_out,
    output logic       aux_start_stop,
    output logic [7:0] rx_byte,
    output logic       rx_byte_vld,
    output logic       rx_end,
    output logic       timer_timeout
);

    logic                   tx_vld_q;
    logic                   timer_armed;
    logic [AUX_TIMER_W-1:0] timer_cnt;

    // Drive only during our own frame, otherwise the sink owns the bus
    assign aux_in_out     = tx_byte_vld ? tx_byte : 8'bz;
    assign aux_start_stop = tx_byte_vld;

    // ========================================
    // Receive path
    // ========================================

    always_ff @(posedge clk) begin
        if (phy_start_stop) begin
            rx_byte <= aux_in_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_byte_vld <= 1'b0;
            rx_end      <= 1'b0;
        end else begin
            rx_byte_vld <= phy_start_stop;
            // Last byte was sampled but the PHY has dropped its strobe
            rx_end      <= rx_byte_vld && !phy_start_stop;
        end
    end

    // ========================================
    // Reply timeout
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_vld_q      <= 1'b0;
            timer_armed   <= 1'b0;
            timer_cnt     <= '0;
            timer_timeout <= 1'b0;
        end else begin
            tx_vld_q      <= tx_byte_vld;
            timer_timeout <= 1'b0;
            if (tx_vld_q && !tx_byte_vld) begin
                timer_armed <= 1'b1;
                timer_cnt   <= '0;
            end else if (phy_start_stop) begin
                timer_armed <= 1'b0;
            end else if (timer_armed) begin
                timer_cnt <= timer_cnt + 1'b1;
                if (timer_cnt == AUX_TIMER_W'(AUX_REPLY_TIMEOUT - 1)) begin
                    timer_armed   <= 1'b0;
                    timer_timeout <= 1'b1;
                end
            end
        end
    end

endmodule

// File: source/reply_decoder.sv
module reply_decoder import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_byte_vld,
    output aux_ack_e   reply_ack,
    output logic       reply_ack_vld,
    output logic [7:0] reply_data,
    output logic       reply_data_vld
);

    // Set between frames, cleared by the ack byte
    logic first_byte;

    always_ff @(posedge clk) begin
        if (rx_byte_vld && first_byte) begin
            // Reply code sits in bits 5:4 of the upper nibble
            reply_ack <= aux_ack_e'(rx_byte[5:4]);
        end
        if (rx_byte_vld && !first_byte) begin
            reply_data <= rx_byte;
        end
    end

    // ========================================
    // Frame tracking
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_byte     <= 1'b1;
            reply_ack_vld  <= 1'b0;
            reply_data_vld <= 1'b0;
        end else begin
            reply_ack_vld  <= rx_byte_vld && first_byte;
            reply_data_vld <= rx_byte_vld && !first_byte;
            if (!rx_byte_vld) begin
                first_byte <= 1'b1;
            end else begin
                first_byte <= 1'b0;
            end
        end
    end

endmodule

// File: source/hpd_detect.sv
module hpd_detect import aux_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic hpd_signal,
    output logic hpd_detect,
    output logic hpd_irq
);

    logic [1:0]           hpd_sync;
    logic                 level_q;
    logic [HPD_CNT_W-1:0] run_cnt;
    logic                 irq_width;

    // Width of the low run that just ended
    assign irq_width = (run_cnt >= HPD_CNT_W'(HPD_IRQ_MIN)) &&
                       (run_cnt <= HPD_CNT_W'(HPD_IRQ_MAX));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hpd_sync   <= '0;
            level_q    <= 1'b0;
            run_cnt    <= '0;
            hpd_detect <= 1'b0;
            hpd_irq    <= 1'b0;
        end else begin
            hpd_sync <= {hpd_sync[0], hpd_signal};
            level_q  <= hpd_sync[1];
            hpd_irq  <= 1'b0;
            if (hpd_sync[1] != level_q) begin
                run_cnt <= HPD_CNT_W'(1);
                // Rising edge closes a low pulse
                if (hpd_sync[1] && irq_width && hpd_detect) begin
                    hpd_irq <= 1'b1;
                end
            end else if (run_cnt != HPD_CNT_W'(HPD_PLUG_CYCLES)) begin
                run_cnt <= run_cnt + 1'b1;
                if (run_cnt == HPD_CNT_W'(HPD_PLUG_CYCLES - 1)) begin
                    hpd_detect <= hpd_sync[1];
                end
            end
        end
    end

endmodule

// File: source/aux_top.sv
module aux_top import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spm_transaction_vld,
    input  aux_req_t   spm_req,
    input  logic       lpm_transaction_vld,
    input  aux_req_t   lpm_req,
    input  logic       phy_start_stop,
    input  logic       hpd_signal,
    inout  wire  [7:0] aux_in_out,
    output logic       aux_start_stop,
    output logic       timer_timeout,
    output logic       req_done,
    output aux_owner_e reply_owner,
    output logic       ctrl_native_failed,
    output aux_ack_e   reply_ack,
    output logic       reply_ack_vld,
    output logic [7:0] reply_data,
    output logic       reply_data_vld,
    output logic       hpd_detect,
    output logic       hpd_irq
);

    // Control unit to encoder
    logic       tx_start;
    aux_req_t   tx_req;
    logic       tx_done;

    // Encoder to PHY
    logic [7:0] tx_byte;
    logic       tx_byte_vld;

    // PHY to reply decoder
    logic [7:0] rx_byte;
    logic       rx_byte_vld;
    logic       rx_end;

    aux_ctrl_unit u_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .spm_transaction_vld (spm_transaction_vld),
        .spm_req             (spm_req),
        .lpm_transaction_vld (lpm_transaction_vld),
        .lpm_req             (lpm_req),
        .reply_ack           (reply_ack),
        .reply_ack_vld       (reply_ack_vld),
        .rx_end              (rx_end),
        .timer_timeout       (timer_timeout),
        .tx_done             (tx_done),
        .tx_start            (tx_start),
        .tx_req              (tx_req),
        .req_done            (req_done),
        .reply_owner         (reply_owner),
        .ctrl_native_failed  (ctrl_native_failed)
    );

    native_message_encoder u_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start    (tx_start),
        .tx_req      (tx_req),
        .tx_byte     (tx_byte),
        .tx_byte_vld (tx_byte_vld),
        .tx_done     (tx_done)
    );

    aux_phy_interface u_phy (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_byte        (tx_byte),
        .tx_byte_vld    (tx_byte_vld),
        .phy_start_stop (phy_start_stop),
        .aux_in_out     (aux_in_out),
        .aux_start_stop (aux_start_stop),
        .rx_byte        (rx_byte),
        .rx_byte_vld    (rx_byte_vld),
        .rx_end         (rx_end),
        .timer_timeout  (timer_timeout)
    );

    reply_decoder u_reply (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_byte        (rx_byte),
        .rx_byte_vld    (rx_byte_vld),
        .reply_ack      (reply_ack),
        .reply_ack_vld  (reply_ack_vld),
        .reply_data     (reply_data),
        .reply_data_vld (reply_data_vld)
    );

    hpd_detect u_hpd (
        .clk        (clk),
        .rst_n      (rst_n),
        .hpd_signal (hpd_signal),
        .hpd_detect (hpd_detect),
        .hpd_irq    (hpd_irq)
    );

endmodule

// File: tb/tb_aux_top.sv
module tb_aux_top import aux_pkg::*; ();

    // Words per test row in the input file
    localparam int          FIELDS    = 10;
    localparam int          MAX_TESTS = 16;
    localparam logic [31:0] LFSR_SEED = 32'd97484;

    logic       clk;
    logic       rst_n;
    logic       spm_transaction_vld;
    aux_req_t   spm_req;
    logic       lpm_transaction_vld;
    aux_req_t   lpm_req;
    logic       phy_start_stop;
    logic       hpd_signal;
    wire  [7:0] aux_in_out;
    logic       aux_start_stop;
    logic       timer_timeout;
    logic       req_done;
    aux_owner_e reply_owner;
    logic       ctrl_native_failed;
    aux_ack_e   reply_ack;
    logic       reply_ack_vld;
    logic [7:0] reply_data;
    logic       reply_data_vld;
    logic       hpd_detect;
    logic       hpd_irq;

    logic [31:0] test_mem [0:FIELDS*MAX_TESTS-1];
    logic [7:0]  sink_byte;
    logic [7:0]  frame_q [$];
    logic [7:0]  rx_data_q [$];
    aux_ack_e    ack_seen_q [$];
    logic [31:0] sink_lfsr;
    logic [31:0] exp_lfsr;
    aux_req_t    exp_req;
    string       cur_name;
    int          cur_defers;
    int          cur_silent;
    int          cur_gap;
    int          defers_sent;
    int          frames_seen = 0;
    int          timeouts_seen = 0;
    int          irqs_seen = 0;
    int          test_errors = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic        prev_ss = 1'b0;
    event        frame_ended;

    // Sink side of the bidirectional AUX bus
    assign aux_in_out = phy_start_stop ? sink_byte : 8'bz;

    aux_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_byte(inout logic [31:0] st, output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = st[0];
            st   = lfsr_step(st);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // Header rule and then the data byte on writes
    function automatic logic [7:0] frame_byte(input aux_req_t r, input int idx);
        case (idx)
            0:       return {4'(AUX_HDR_CMD_BASE + int'(r.cmd)), r.address[19:16]};
            1:       return r.address[15:8];
            2:       return r.address[7:0];
            3:       return r.len;
            default: return r.data;
        endcase
    endfunction

    // Worst case has every attempt run into the reply timeout
    function automatic int test_cycles(input int base);
        if (test_mem[base] != 0) begin
            return 3 * HPD_PLUG_CYCLES + test_mem[base+8] + 30;
        end
        return (AUX_MAX_RETRY + 1) *
               (5 + AUX_REPLY_TIMEOUT + test_mem[base+8] + test_mem[base+4] + 4) + 10;
    endfunction

    // ========================================
    // Bus monitor and sink model
    // ========================================

    always @(posedge clk) begin
        if (aux_start_stop) begin
            frame_q.push_back(aux_in_out);
        end
        if (prev_ss && !aux_start_stop) begin
            check_value("frame length", (exp_req.cmd == CMD_WRITE) ? 5 : 4, frame_q.size());
            foreach (frame_q[i]) begin
                check_value($sformatf("frame byte %0d", i), frame_byte(exp_req, i), frame_q[i]);
            end
            frame_q.delete();
            frames_seen++;
            -> frame_ended;
        end
        if (timer_timeout) begin
            timeouts_seen++;
        end
        if (hpd_irq) begin
            irqs_seen++;
        end
        if (reply_ack_vld) begin
            ack_seen_q.push_back(reply_ack);
        end
        if (reply_data_vld) begin
            rx_data_q.push_back(reply_data);
        end
        prev_ss = aux_start_stop;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Run stopped, no result within the limit of %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // Ack code sits in bits 5:4 and read data follows an ACK
    task automatic send_reply();
        logic [7:0] b;
        int         n_data;
        n_data = 0;
        repeat (cur_gap) @(negedge clk);
        phy_start_stop = 1'b1;
        if (defers_sent < cur_defers) begin
            defers_sent++;
            sink_byte = {2'b00, ACK_DEFER, 4'h0};
        end else begin
            sink_byte = {2'b00, ACK_ACK, 4'h0};
            if (exp_req.cmd == CMD_READ) begin
                n_data = exp_req.len + 1;
            end
        end
        for (int i = 0; i < n_data; i++) begin
            @(negedge clk);
            random_byte(sink_lfsr, b);
            sink_byte = b;
        end
        @(negedge clk);
        phy_start_stop = 1'b0;
    endtask

    initial begin
        forever begin
            @(frame_ended);
            if (cur_silent == 0) begin
                send_reply();
            end
        end
    end

    // ========================================
    // Test sequences
    // ========================================

    task automatic run_aux(input int base);
        aux_req_t   req;
        aux_owner_e owner_seen;
        logic       failed_seen;
        logic [7:0] b;
        int         owner;
        int         attempts;
        int         n_data;
        req.cmd     = aux_cmd_e'(test_mem[base+2][1:0]);
        req.address = test_mem[base+3][19:0];
        req.len     = test_mem[base+4][7:0];
        req.data    = test_mem[base+5][7:0];
        owner       = test_mem[base+1];
        cur_defers  = test_mem[base+6];
        cur_silent  = test_mem[base+7];
        cur_gap     = test_mem[base+8];
        cur_name    = $sformatf("%s_%s_%0d", (req.cmd == CMD_READ) ? "read" : "write",
                                (owner == 0) ? "spm" : (owner == 1) ? "lpm" : "both",
                                base / FIELDS);
        if (cur_silent != 0 || cur_defers > AUX_MAX_RETRY) begin
            attempts = AUX_MAX_RETRY + 1;
        end else begin
            attempts = cur_defers + 1;
        end
        n_data = (test_mem[base+9] == 0 && req.cmd == CMD_READ) ? req.len + 1 : 0;
        defers_sent   = 0;
        frames_seen   = 0;
        timeouts_seen = 0;
        rx_data_q.delete();
        ack_seen_q.delete();
        exp_req = req;

        @(negedge clk);
        spm_req = req;
        lpm_req = req;
        // The losing spm request points elsewhere so a wrong frame shows up
        spm_req.address     = (owner == 2) ? ~req.address : req.address;
        spm_transaction_vld = (owner != 1);
        lpm_transaction_vld = (owner != 0);
        @(negedge clk);
        spm_transaction_vld = 1'b0;
        lpm_transaction_vld = 1'b0;

        @(posedge clk);
        while (!req_done) begin
            @(posedge clk);
        end
        failed_seen = ctrl_native_failed;
        owner_seen  = reply_owner;
        @(negedge clk);

        check_value("frames", attempts, frames_seen);
        check_value("timeouts", (cur_silent != 0) ? AUX_MAX_RETRY + 1 : 0, timeouts_seen);
        check_value("ctrl_native_failed", test_mem[base+9], failed_seen);
        check_value("reply_owner", (owner == 0) ? OWNER_SPM : OWNER_LPM, owner_seen);
        // One ack per answered attempt, defers come first
        check_value("reply ack count", (cur_silent != 0) ? 0 : attempts, ack_seen_q.size());
        for (int i = 0; i < ack_seen_q.size(); i++) begin
            check_value($sformatf("reply ack %0d", i),
                        (i < cur_defers) ? ACK_DEFER : ACK_ACK, ack_seen_q[i]);
        end
        check_value("reply data count", n_data, rx_data_q.size());
        for (int i = 0; i < n_data; i++) begin
            random_byte(exp_lfsr, b);
            if (i < rx_data_q.size()) begin
                check_value($sformatf("reply data %0d", i), b, rx_data_q[i]);
            end
        end
    endtask

    task automatic run_hpd(input int base);
        int width;
        width    = test_mem[base+8];
        cur_name = $sformatf("hpd_low_%0d_%0d", width, base / FIELDS);
        @(negedge clk);
        hpd_signal = 1'b1;
        repeat (HPD_PLUG_CYCLES + 5) @(negedge clk);
        check_value("hpd_detect after high", 1, hpd_detect);
        irqs_seen  = 0;
        hpd_signal = 1'b0;
        repeat (width) @(negedge clk);
        hpd_signal = 1'b1;
        repeat (HPD_PLUG_CYCLES) @(negedge clk);
        check_value("hpd_irq count", test_mem[base+9], irqs_seen);
        check_value("hpd_detect after pulse", 1, hpd_detect);
        hpd_signal = 1'b0;
        repeat (HPD_PLUG_CYCLES + 5) @(negedge clk);
        check_value("hpd_detect after low", 0, hpd_detect);
    endtask

    initial begin : main_seq
        int n_tests;
        int n_pass;
        int n_fail;
        rst_n               = 1'b0;
        spm_transaction_vld = 1'b0;
        lpm_transaction_vld = 1'b0;
        spm_req             = '0;
        lpm_req             = '0;
        phy_start_stop      = 1'b0;
        hpd_signal          = 1'b0;
        sink_byte           = '0;
        exp_req             = '0;
        cur_defers          = 0;
        cur_silent          = 1;
        cur_gap             = 1;
        sink_lfsr           = LFSR_SEED;
        exp_lfsr            = LFSR_SEED;
        n_tests             = 0;
        n_pass              = 0;
        n_fail              = 0;

        $readmemh("tb/aux_input.txt", test_mem);
        // Kind f ends the list
        while (n_tests < MAX_TESTS && test_mem[n_tests*FIELDS] < 2) begin
            n_tests++;
        end
        cycle_limit = 8 + 50;
        for (int t = 0; t < n_tests; t++) begin
            cycle_limit += test_cycles(t * FIELDS) + 3;
        end
        if (n_tests == 0) begin
            $display("No tests found in tb/aux_input.txt");
            n_fail = 1;
        end

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        for (int t = 0; t < n_tests; t++) begin
            test_errors = 0;
            if (test_mem[t*FIELDS] == 0) begin
                run_aux(t * FIELDS);
            end else begin
                run_hpd(t * FIELDS);
            end
            if (test_errors == 0) begin
                $display("PASS %s", cur_name);
                n_pass++;
            end else begin
                $display("FAIL %s with %0d mismatches", cur_name, test_errors);
                n_fail++;
            end
            repeat (3) @(negedge clk);
        end

        $display("%0d tests run, %0d passed, %0d failed", n_tests, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/aux_input.txt
// kind(0 aux, 1 hpd, f end) owner(0 spm, 1 lpm, 2 both) cmd(0 write, 1 read) address len data
// defers silent gap(cycles, at least 1) expect(aux failed flag, hpd irq count), hpd gap is low width
0 0 1 12345 3 00 0 0 2 0
0 1 0 4a0bc 0 5a 0 0 1 0
0 0 1 00300 1 00 2 0 3 0
0 1 0 00404 0 c3 3 0 5 0
0 0 1 00500 0 00 4 0 1 1
0 1 0 00600 0 e7 0 1 1 1
0 2 1 08000 2 00 0 0 1 0
1 0 0 00000 0 00 0 0 6 1
1 0 0 00000 0 00 0 0 e 0
f 0 0 00000 0 00 0 0 0 0

// File: sources.f
source/aux_pkg.sv
source/aux_ctrl_unit.sv
source/native_message_encoder.sv
source/aux_phy_interface.sv
source/reply_decoder.sv
source/hpd_detect.sv
source/aux_top.sv
tb/tb_aux_top.sv

// File: Bender.yml
package:
  name: aux_native_engine

sources:
  - source/aux_pkg.sv
  - source/aux_ctrl_unit.sv
  - source/native_message_encoder.sv
  - source/aux_phy_interface.sv
  - source/reply_decoder.sv
  - source/hpd_detect.sv
  - source/aux_top.sv
  - target: simulation
    files:
      - tb/tb_aux_top.sv
